/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_rv_decoder -f src.f -o tb_rv_decoder
out=$(./obj_dir/tb_rv_decoder)
echo "$out"
if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

/* src.f */
+incdir+verif
verilog/decode_pkg.sv
verilog/exec_decoder.sv
verilog/mem_decoder.sv
verilog/imm_gen.sv
verilog/decode_stage.sv
verilog/rv_decoder_top.sv
verif/tb_rv_decoder.sv

/* verif/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// integer op from funct3, alt picks sub or sra
function automatic alu_op_e model_int_op(input funct3_t f3, input logic alt);
    case (f3)
        3'b000:  return alt ? ALU_SUB : ALU_ADD;
        3'b001:  return ALU_SLL;
        3'b010:  return ALU_SLT;
        3'b011:  return ALU_SLTU;
        3'b100:  return ALU_XOR;
        3'b101:  return alt ? ALU_SRA : ALU_SRL;
        3'b110:  return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

// execute side, returns the hit
function automatic logic model_exec(input word_t w, output exec_ctrl_t e,
                                    output imm_kind_e kind);
    opcode_t op;
    funct3_t f3;
    funct7_t f7;
    logic    ok;
    op   = w[6:0];
    f3   = w[14:12];
    f7   = w[31:25];
    e    = EXEC_IDLE;
    kind = IMM_NONE;
    ok   = 1'b0;
    if (op == OPC_OP && (f7 == F7_BASE ||
                         (f7 == F7_ALT && (f3 == 3'b000 || f3 == 3'b101)))) begin
        ok        = 1'b1;
        e.alu_op  = model_int_op(f3, f7 == F7_ALT);
        e.alu_src = SRC_RS_RS;
        e.req_rf  = 1'b1;
    end else if (op == OPC_OP && f7 == F7_MULDIV) begin
        ok           = 1'b1;
        e.req_rf     = 1'b1;
        e.is_mul     = ~f3[2];
        e.mul_high   = ~f3[2] & (f3[1] | f3[0]);
        e.is_div     = f3[2];
        e.div_signed = f3[2] & ~f3[0];
        e.div_rem    = f3[2] & f3[1];
        // mul and mulhu are both unsigned
        if (!f3[2]) begin
            e.mul_sign = (f3[1:0] == 2'b01) ? MUL_SS :
                         (f3[1:0] == 2'b10) ? MUL_SU : MUL_UU;
        end
    end else if (op == OPC_OP_IMM && (f3 != 3'b101 || f7 == F7_BASE || f7 == F7_ALT)) begin
        ok        = 1'b1;
        kind      = IMM_I;
        e.alu_op  = model_int_op(f3, f3 == 3'b101 && f7 == F7_ALT);
        e.alu_src = SRC_RS_IMM;
        e.req_rf  = 1'b1;
    end else if (op == OPC_BRANCH && f3 != 3'b010 && f3 != 3'b011) begin
        ok        = 1'b1;
        kind      = IMM_B;
        e.is_bj   = 1'b1;
        e.bju_src = BJU_PC_IMM;
        e.alu_src = SRC_RS_RS;
        e.alu_op  = (f3 == 3'b000) ? ALU_EQ : (f3 == 3'b001) ? ALU_NE :
                    (f3 == 3'b100) ? ALU_LT : (f3 == 3'b101) ? ALU_GE :
                    (f3 == 3'b110) ? ALU_LTU : ALU_GEU;
    end else if (op == OPC_LUI || op == OPC_AUIPC) begin
        ok        = 1'b1;
        kind      = IMM_U;
        e.alu_op  = ALU_ADD;
        e.alu_src = (op == OPC_LUI) ? SRC_ZERO_IMM : SRC_PC_IMM;
        e.req_rf  = 1'b1;
    end else if (op == OPC_JAL || op == OPC_JALR) begin
        ok        = 1'b1;
        kind      = (op == OPC_JAL) ? IMM_J : IMM_I;
        e.is_bj   = 1'b1;
        e.bju_src = (op == OPC_JAL) ? BJU_PC_IMM : BJU_RS_IMM;
        e.alu_op  = ALU_ADD;
        e.alu_src = SRC_PC_4;
        e.req_rf  = 1'b1;
    end
    return ok;
endfunction

// memory side, returns the hit
function automatic logic model_mem(input word_t w, output mem_ctrl_t m,
                                   output imm_kind_e kind);
    funct3_t f3;
    logic    ld;
    logic    st;
    logic    ok;
    f3   = w[14:12];
    ld   = (w[6:0] == OPC_LOAD);
    st   = (w[6:0] == OPC_STORE);
    ok   = (ld && f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) ||
           (st && f3 inside {3'b000, 3'b001, 3'b010});
    m    = MEM_IDLE;
    kind = IMM_NONE;
    if (ok) begin
        m.is_load     = ld;
        m.is_store    = st;
        m.load_signed = ld && !f3[2];
        m.size        = (f3[1:0] == 2'b00) ? SIZE_BYTE :
                        (f3[1:0] == 2'b01) ? SIZE_HALF : SIZE_WORD;
        m.byte_mask   = (f3[1:0] == 2'b00) ? 4'b0001 :
                        (f3[1:0] == 2'b01) ? 4'b0011 : 4'b1111;
        kind          = ld ? IMM_I : IMM_S;
    end
    return ok;
endfunction

function automatic word_t model_imm(input word_t w, input imm_kind_e kind);
    case (kind)
        IMM_I:   return word_t'($signed(w) >>> 20);
        IMM_S:   return {{20{w[31]}}, w[31:25], w[11:7]};
        IMM_B:   return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        IMM_U:   return {w[31:12], 12'h000};
        IMM_J:   return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        default: return '0;
    endcase
endfunction

function automatic decode_t model_decode(input word_t w);
    decode_t    d;
    exec_ctrl_t e;
    mem_ctrl_t  m;
    imm_kind_e  ke;
    imm_kind_e  km;
    logic       he;
    logic       hm;
    he        = model_exec(w, e, ke);
    hm        = model_mem(w, m, km);
    d.rs1     = w[19:15];
    d.rs2     = w[24:20];
    d.rd      = w[11:7];
    d.imm     = model_imm(w, hm ? km : ke);
    d.exec    = e;
    d.mem     = m;
    d.req_rf  = e.req_rf | m.is_load;
    d.illegal = !(he || hm);
    return d;
endfunction

`endif

/* verif/tb_rv_decoder.sv */
`timescale 1ns/10ps

module tb_rv_decoder;
    import decode_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 2000;

    logic    clk = 1'b0;
    logic    rst_n_i = 1'b0;
    logic    inst_valid_i = 1'b0;
    word_t   inst_i = '0;
    logic    dec_valid_o;
    decode_t decode_o;

    integer  seed = 25783;
    int      error_count = 0;
    int      check_count = 0;
    decode_t exp_q[$];
    decode_t last_exp = '0;
    logic    valid_pipe = 1'b0;

    `include "decode_model.svh"

    rv_decoder_top UUT (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .dec_valid_o  (dec_valid_o),
        .decode_o     (decode_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_exec(input string name, input exec_ctrl_t got, input exec_ctrl_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mem(input string name, input mem_ctrl_t got, input mem_ctrl_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input rf_addr_t got, input rf_addr_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_record(input decode_t got, input decode_t exp);
        check_addr("decode_o.rs1", got.rs1, exp.rs1);
        check_addr("decode_o.rs2", got.rs2, exp.rs2);
        check_addr("decode_o.rd", got.rd, exp.rd);
        check_word("decode_o.imm", got.imm, exp.imm);
        check_exec("decode_o.exec", got.exec, exp.exec);
        check_mem("decode_o.mem", got.mem, exp.mem);
        check_bit("decode_o.req_rf", got.req_rf, exp.req_rf);
        check_bit("decode_o.illegal", got.illegal, exp.illegal);
    endtask

    // steer a random word into one instruction class
    function automatic word_t make_word(input int kind, input word_t r, input word_t s);
        word_t w;
        w = r;
        case (kind)
            0: begin
                w[6:0] = OPC_OP;
                // s[1:0] == 3 leaves a random funct7
                case (s[1:0])
                    2'd0:    w[31:25] = F7_BASE;
                    2'd1:    w[31:25] = F7_ALT;
                    2'd2:    w[31:25] = F7_MULDIV;
                    default: w[31:25] = r[31:25];
                endcase
            end
            1: begin
                w[6:0] = OPC_OP_IMM;
                if (s[2]) begin
                    w[31:25] = s[3] ? F7_ALT : F7_BASE;
                end
            end
            2:       w[6:0] = OPC_LOAD;
            3:       w[6:0] = OPC_STORE;
            4:       w[6:0] = OPC_BRANCH;
            5:       w[6:0] = s[0] ? OPC_JAL : OPC_JALR;
            6:       w[6:0] = s[0] ? OPC_LUI : OPC_AUIPC;
            // system and misc-mem
            7:       w[6:0] = s[0] ? 7'b1110011 : 7'b0001111;
            default: w = r;
        endcase
        return w;
    endfunction

    initial begin
        word_t rnd;
        word_t r;
        word_t s;
        int    sent;
        sent = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        while (sent < NUM_TESTS) begin
            @(posedge clk);
            rnd = $random(seed);
            r   = $random(seed);
            s   = $random(seed);
            if (rnd[1:0] != 2'b00) begin
                inst_valid_i <= 1'b1;
                inst_i       <= make_word(int'(rnd[15:8]) % 9, r, s);
                sent++;
            end else begin
                // junk on the bus while idle
                inst_valid_i <= 1'b0;
                inst_i       <= r;
            end
        end
        @(posedge clk);
        inst_valid_i <= 1'b0;
        @(posedge clk);
        while (exp_q.size() != 0) @(posedge clk);
        @(posedge clk);
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // inputs and outputs are both settled at the falling edge
    initial begin
        @(posedge clk);
        forever begin
            @(negedge clk);
            check_bit("dec_valid_o", dec_valid_o, valid_pipe);
            if (dec_valid_o) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("ERROR at %0t: a decode record was presented but none was pending",
                             $time);
                end else begin
                    last_exp = exp_q.pop_front();
                end
            end
            // idle cycles must hold the last record
            compare_record(decode_o, last_exp);
            valid_pipe = inst_valid_i && rst_n_i;
            if (valid_pipe) begin
                exp_q.push_back(model_decode(inst_i));
            end
        end
    end

    initial begin
        #(RESET_CYCLES * CLK_PERIOD + 2 * NUM_TESTS * CLK_PERIOD);
        $display("timeout: the run did not complete %0d tests in time", NUM_TESTS);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* verilog/decode_pkg.sv */
package decode_pkg;

    localparam int XLEN      = 32;
    localparam int RF_ADDR_W = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [RF_ADDR_W-1:0] rf_addr_t;
    typedef logic [6:0]           opcode_t;
    typedef logic [2:0]           funct3_t;
    typedef logic [6:0]           funct7_t;
    typedef logic [3:0]           byte_mask_t;

    // major opcodes
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000;
    localparam funct7_t F7_MULDIV = 7'b0000001;

    // integer ops, shared by OP and OP_IMM
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SRL  = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // access widths of loads and stores
    localparam funct3_t F3_BYTE   = 3'b000;
    localparam funct3_t F3_HALF   = 3'b001;
    localparam funct3_t F3_WORD   = 3'b010;
    localparam funct3_t F3_BYTE_U = 3'b100;
    localparam funct3_t F3_HALF_U = 3'b101;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
    } alu_op_e;

    typedef enum logic [2:0] {
        SRC_NONE, SRC_RS_RS, SRC_RS_IMM, SRC_ZERO_IMM, SRC_PC_IMM, SRC_PC_4
    } alu_src_e;

    typedef enum logic [1:0] {BJU_NONE, BJU_PC_IMM, BJU_RS_IMM} bju_src_e;

    typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_e;

    // operand signedness, rs1 then rs2
    typedef enum logic [1:0] {MUL_SS, MUL_SU, MUL_UU} mul_sign_e;

    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;

    typedef struct packed {
        alu_op_e   alu_op;
        alu_src_e  alu_src;
        logic      is_bj;
        bju_src_e  bju_src;
        logic      is_mul;
        mul_sign_e mul_sign;
        logic      mul_high;
        logic      is_div;
        logic      div_signed;
        logic      div_rem;
        logic      req_rf;
    } exec_ctrl_t;

    typedef struct packed {
        logic       is_load;
        logic       is_store;
        mem_size_e  size;
        logic       load_signed;
        byte_mask_t byte_mask;
    } mem_ctrl_t;

    typedef struct packed {
        rf_addr_t   rs1;
        rf_addr_t   rs2;
        rf_addr_t   rd;
        word_t      imm;
        exec_ctrl_t exec;
        mem_ctrl_t  mem;
        logic       req_rf;
        logic       illegal;
    } decode_t;

    localparam exec_ctrl_t EXEC_IDLE = '{
        alu_op:     ALU_NOP,
        alu_src:    SRC_NONE,
        is_bj:      1'b0,
        bju_src:    BJU_NONE,
        is_mul:     1'b0,
        mul_sign:   MUL_SS,
        mul_high:   1'b0,
        is_div:     1'b0,
        div_signed: 1'b0,
        div_rem:    1'b0,
        req_rf:     1'b0
    };

    localparam mem_ctrl_t MEM_IDLE = '{
        is_load:     1'b0,
        is_store:    1'b0,
        size:        SIZE_BYTE,
        load_signed: 1'b0,
        byte_mask:   4'b0000
    };

endpackage

/* verilog/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   inst_valid_i,
    input  decode_pkg::word_t      inst_i,
    input  decode_pkg::exec_ctrl_t exec_i,
    input  decode_pkg::imm_kind_e  exec_imm_i,
    input  logic                   exec_hit_i,
    input  decode_pkg::mem_ctrl_t  mem_i,
    input  decode_pkg::imm_kind_e  mem_imm_i,
    input  logic                   mem_hit_i,
    output logic                   dec_valid_o,
    output decode_pkg::decode_t    decode_o
);
    import decode_pkg::*;

    imm_kind_e imm_kind;
    word_t     imm;
    logic      hit;
    decode_t   dec_next;

    // a decoder that misses reports IMM_NONE
    assign imm_kind = exec_hit_i ? exec_imm_i : mem_imm_i;
    assign hit      = exec_hit_i | mem_hit_i;

    imm_gen u_imm_gen (
        .inst_i (inst_i),
        .kind_i (imm_kind),
        .imm_o  (imm)
    );

    always_comb begin
        dec_next.rs1     = inst_i[19:15];
        dec_next.rs2     = inst_i[24:20];
        dec_next.rd      = inst_i[11:7];
        dec_next.imm     = imm;
        dec_next.exec    = exec_i;
        dec_next.mem     = mem_i;
        dec_next.req_rf  = exec_i.req_rf | mem_i.is_load;
        dec_next.illegal = ~hit;
    end

    // one register stage, record held while idle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
            decode_o    <= '0;
        end else begin
            dec_valid_o <= inst_valid_i;
            if (inst_valid_i) begin
                decode_o <= dec_next;
            end
        end
    end

endmodule

/* verilog/exec_decoder.sv */
`timescale 1ns/10ps

module exec_decoder (
    input  decode_pkg::word_t      inst_i,
    output decode_pkg::exec_ctrl_t exec_o,
    output decode_pkg::imm_kind_e  exec_imm_o,
    output logic                   exec_hit_o
);
    import decode_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // base integer op for a funct3
    function automatic alu_op_e base_op(input funct3_t f3);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SRL:  op = ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_NOP;
        endcase
        return op;
    endfunction

    always_comb begin
        exec_o     = EXEC_IDLE;
        exec_imm_o = IMM_NONE;
        exec_hit_o = 1'b0;
        case (opcode)
            OPC_OP: begin
                exec_o.req_rf = 1'b1;
                case (funct7)
                    F7_BASE: begin
                        exec_hit_o     = 1'b1;
                        exec_o.alu_op  = base_op(funct3);
                        exec_o.alu_src = SRC_RS_RS;
                    end
                    F7_ALT: begin
                        // only sub and sra exist here
                        exec_hit_o     = (funct3 == F3_ADD) || (funct3 == F3_SRL);
                        exec_o.alu_op  = (funct3 == F3_ADD) ? ALU_SUB : ALU_SRA;
                        exec_o.alu_src = SRC_RS_RS;
                    end
                    F7_MULDIV: begin
                        exec_hit_o = 1'b1;
                        if (!funct3[2]) begin
                            exec_o.is_mul   = 1'b1;
                            exec_o.mul_high = (funct3[1:0] != 2'b00);
                            case (funct3[1:0])
                                2'b01:   exec_o.mul_sign = MUL_SS;
                                2'b10:   exec_o.mul_sign = MUL_SU;
                                default: exec_o.mul_sign = MUL_UU;
                            endcase
                        end else begin
                            // div, divu, rem, remu
                            exec_o.is_div     = 1'b1;
                            exec_o.div_signed = ~funct3[0];
                            exec_o.div_rem    = funct3[1];
                        end
                    end
                    default: exec_hit_o = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                exec_hit_o     = 1'b1;
                exec_imm_o     = IMM_I;
                exec_o.alu_op  = base_op(funct3);
                exec_o.alu_src = SRC_RS_IMM;
                exec_o.req_rf  = 1'b1;
                if (funct3 == F3_SRL) begin
                    if (funct7 == F7_ALT) begin
                        exec_o.alu_op = ALU_SRA;
                    end else if (funct7 != F7_BASE) begin
                        exec_hit_o = 1'b0;
                    end
                end
            end
            OPC_BRANCH: begin
                exec_hit_o     = 1'b1;
                exec_imm_o     = IMM_B;
                exec_o.is_bj   = 1'b1;
                exec_o.bju_src = BJU_PC_IMM;
                exec_o.alu_src = SRC_RS_RS;
                case (funct3)
                    F3_BEQ:  exec_o.alu_op = ALU_EQ;
                    F3_BNE:  exec_o.alu_op = ALU_NE;
                    F3_BLT:  exec_o.alu_op = ALU_LT;
                    F3_BGE:  exec_o.alu_op = ALU_GE;
                    F3_BLTU: exec_o.alu_op = ALU_LTU;
                    F3_BGEU: exec_o.alu_op = ALU_GEU;
                    default: exec_hit_o = 1'b0;
                endcase
            end
            OPC_LUI, OPC_AUIPC: begin
                exec_hit_o     = 1'b1;
                exec_imm_o     = IMM_U;
                exec_o.alu_op  = ALU_ADD;
                exec_o.alu_src = (opcode == OPC_LUI) ? SRC_ZERO_IMM : SRC_PC_IMM;
                exec_o.req_rf  = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                // link value pc+4 goes through the alu
                exec_hit_o     = 1'b1;
                exec_imm_o     = (opcode == OPC_JAL) ? IMM_J : IMM_I;
                exec_o.is_bj   = 1'b1;
                exec_o.bju_src = (opcode == OPC_JAL) ? BJU_PC_IMM : BJU_RS_IMM;
                exec_o.alu_op  = ALU_ADD;
                exec_o.alu_src = SRC_PC_4;
                exec_o.req_rf  = 1'b1;
            end
            default: exec_hit_o = 1'b0;
        endcase

        // unknown funct combination falls back to idle
        if (!exec_hit_o) begin
            exec_o     = EXEC_IDLE;
            exec_imm_o = IMM_NONE;
        end
    end

endmodule

/* verilog/imm_gen.sv */
`timescale 1ns/10ps

module imm_gen (
    input  decode_pkg::word_t     inst_i,
    input  decode_pkg::imm_kind_e kind_i,
    output decode_pkg::word_t     imm_o
);
    import decode_pkg::*;

    logic sign;

    // bit 31 is the sign of every format
    assign sign = inst_i[31];

    always_comb begin
        case (kind_i)
            IMM_I: begin
                imm_o = {{20{sign}}, inst_i[31:20]};
            end
            IMM_S: begin
                imm_o = {{20{sign}}, inst_i[31:25], inst_i[11:7]};
            end
            IMM_B: begin
                imm_o = {{19{sign}}, inst_i[31], inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {inst_i[31:12], 12'b0};
            end
            IMM_J: begin
                imm_o = {{11{sign}}, inst_i[31], inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

/* verilog/mem_decoder.sv */
`timescale 1ns/10ps

module mem_decoder (
    input  decode_pkg::word_t     inst_i,
    output decode_pkg::mem_ctrl_t mem_o,
    output decode_pkg::imm_kind_e mem_imm_o,
    output logic                  mem_hit_o
);
    import decode_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    is_load;
    logic    is_store;

    assign opcode   = inst_i[6:0];
    assign funct3   = inst_i[14:12];
    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);

    always_comb begin
        mem_o     = MEM_IDLE;
        mem_imm_o = IMM_NONE;
        mem_hit_o = is_load || is_store;
        case (funct3)
            F3_BYTE, F3_BYTE_U: begin
                mem_o.size      = SIZE_BYTE;
                mem_o.byte_mask = 4'b0001;
            end
            F3_HALF, F3_HALF_U: begin
                mem_o.size      = SIZE_HALF;
                mem_o.byte_mask = 4'b0011;
            end
            F3_WORD: begin
                mem_o.size      = SIZE_WORD;
                mem_o.byte_mask = 4'b1111;
            end
            default: mem_hit_o = 1'b0;
        endcase
        // stores have no unsigned forms
        if (is_store && funct3[2]) begin
            mem_hit_o = 1'b0;
        end
        mem_o.is_load     = is_load;
        mem_o.is_store    = is_store;
        mem_o.load_signed = is_load && !funct3[2];
        mem_imm_o         = is_load ? IMM_I : IMM_S;

        if (!mem_hit_o) begin
            mem_o     = MEM_IDLE;
            mem_imm_o = IMM_NONE;
        end
    end

endmodule

/* verilog/rv_decoder_top.sv */
`timescale 1ns/10ps

module rv_decoder_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  decode_pkg::word_t   inst_i,
    output logic                dec_valid_o,
    output decode_pkg::decode_t decode_o
);
    import decode_pkg::*;

    exec_ctrl_t exec;
    imm_kind_e  exec_imm;
    logic       exec_hit;
    mem_ctrl_t  mem;
    imm_kind_e  mem_imm;
    logic       mem_hit;

    exec_decoder u_exec_decoder (
        .inst_i     (inst_i),
        .exec_o     (exec),
        .exec_imm_o (exec_imm),
        .exec_hit_o (exec_hit)
    );

    mem_decoder u_mem_decoder (
        .inst_i    (inst_i),
        .mem_o     (mem),
        .mem_imm_o (mem_imm),
        .mem_hit_o (mem_hit)
    );

    decode_stage u_decode_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .exec_i       (exec),
        .exec_imm_i   (exec_imm),
        .exec_hit_i   (exec_hit),
        .mem_i        (mem),
        .mem_imm_i    (mem_imm),
        .mem_hit_i    (mem_hit),
        .dec_valid_o  (dec_valid_o),
        .decode_o     (decode_o)
    );

endmodule
